//--- project.f
hw/cp0Pkg.sv
hw/cp0Timer.sv
hw/cp0IntCtrl.sv
hw/cp0Regs.sv
hw/cp0Top.sv
sim/cp0Sva.sv
sim/cp0Tb.sv

//--- Bender.yml
package:
  name: cp0

sources:
  - hw/cp0Pkg.sv
  - hw/cp0Timer.sv
  - hw/cp0IntCtrl.sv
  - hw/cp0Regs.sv
  - hw/cp0Top.sv
  - target: simulation
    files:
      - sim/cp0Sva.sv
      - sim/cp0Tb.sv

//--- sim/cp0Tb.sv
`default_nettype none

module cp0Tb;

    localparam int countDivider = 2;
    localparam int clkPeriod    = 10;
    localparam int resetCycles  = 8;
    localparam int sweepCycles  = 32;   // one read of every register number
    localparam int randomCycles = 3000;
    localparam int totalCycles  = sweepCycles + randomCycles;

    logic                         clk;
    logic                         rst;
    logic                         we;
    logic [4:0]                   waddr;
    logic [cp0Pkg::dataWidth-1:0] wdata;
    logic [4:0]                   raddr;
    logic [5:0]                   hwInt;
    logic                         excValid;
    logic [4:0]                   excCode;
    logic [cp0Pkg::dataWidth-1:0] excPc;
    logic [cp0Pkg::dataWidth-1:0] excBadAddr;
    logic                         excInDelay;
    logic                         eret;
    logic [cp0Pkg::dataWidth-1:0] rdata;
    logic                         intReq;
    logic [cp0Pkg::dataWidth-1:0] excVector;
    logic [cp0Pkg::dataWidth-1:0] epcOut;
    logic                         kernelMode;

    // reference model state
    logic [31:0] mStatus;
    logic [31:0] mEpc;
    logic [31:0] mBadVAddr;
    logic [31:0] mConfig;
    logic [31:0] mCount;
    logic [31:0] mCompare;
    logic        mBd;
    logic [4:0]  mExcCode;
    logic [1:0]  mIpSoft;
    logic        mTimerPending;
    logic [5:0]  mHwMeta;
    logic [5:0]  mHwSync;
    int          mPrescale;

    logic [31:0] lfsrState;
    int          errorCount;
    int          checkCount;

    cp0Top #(.countDivider(countDivider)) UUT (.*);

    always #(clkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
        end
        return next;
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState); // one step per bit
            bits[i]   = lfsrState[0];
        end
        return bits;
    endfunction

    function automatic logic [4:0] pickReg(input logic [3:0] idx);
        case (idx)
            4'd0:    return cp0Pkg::regBadVAddr;
            4'd1:    return cp0Pkg::regCount;
            4'd2:    return cp0Pkg::regCompare;
            4'd3:    return cp0Pkg::regStatus;
            4'd4:    return cp0Pkg::regCause;
            4'd5:    return cp0Pkg::regEpc;
            4'd6:    return cp0Pkg::regPrid;
            4'd7:    return cp0Pkg::regConfig;
            4'd8:    return cp0Pkg::regStatus;
            4'd9:    return cp0Pkg::regCause;
            4'd10:   return cp0Pkg::regCount;
            4'd11:   return cp0Pkg::regCompare;
            4'd12:   return 5'd0;  // Index
            4'd13:   return 5'd10; // EntryHi
            4'd14:   return 5'd18; // WatchLo
            default: return 5'd31;
        endcase
    endfunction

    function automatic logic [4:0] pickExc(input logic [2:0] idx);
        case (idx)
            3'd0:    return cp0Pkg::excInt;
            3'd2:    return cp0Pkg::excAdES;
            3'd3:    return cp0Pkg::excSys;
            3'd4:    return cp0Pkg::excBp;
            3'd5:    return cp0Pkg::excRI;
            3'd6:    return cp0Pkg::excOv;
            default: return cp0Pkg::excAdEL;
        endcase
    endfunction

    task automatic resetModel();
        mStatus       = cp0Pkg::statusResetValue;
        mConfig       = cp0Pkg::configResetValue;
        mEpc          = '0;
        mBadVAddr     = '0;
        mCount        = '0;
        mCompare      = '0;
        mBd           = 1'b0;
        mExcCode      = '0;
        mIpSoft       = '0;
        mTimerPending = 1'b0;
        mHwMeta       = '0;
        mHwSync       = '0;
        mPrescale     = 0;
    endtask

    // one clock edge of the model, using the inputs held before the edge
    task automatic stepModel();
        logic oldExl;
        logic tick;
        oldExl = mStatus[1];
        tick   = (mPrescale == countDivider - 1);
        if (we && waddr == cp0Pkg::regCompare) begin
            mTimerPending = 1'b0;
        end else if (mCount == mCompare) begin
            mTimerPending = 1'b1;
        end
        if (we && waddr == cp0Pkg::regCount) begin
            mCount    = wdata;
            mPrescale = 0;
        end else begin
            mCount    = tick ? mCount + 32'd1 : mCount;
            mPrescale = tick ? 0 : mPrescale + 1;
        end
        if (we && waddr == cp0Pkg::regCompare) begin
            mCompare = wdata;
        end
        mHwSync = mHwMeta;
        mHwMeta = hwInt;
        if (excValid) begin
            mStatus[1] = 1'b1;
            mExcCode   = excCode;
            if (!oldExl) begin
                mBd  = excInDelay;
                mEpc = excInDelay ? excPc - 32'd4 : excPc;
            end
            if (excCode == cp0Pkg::excAdEL || excCode == cp0Pkg::excAdES) begin
                mBadVAddr = excBadAddr;
            end
        end else if (eret) begin
            mStatus[1] = 1'b0;
        end else if (we && waddr == cp0Pkg::regStatus) begin
            mStatus[15:8] = wdata[15:8]; // BEV stays as it is
            mStatus[1:0]  = wdata[1:0];
        end
        if (we) begin
            case (waddr)
                cp0Pkg::regEpc:      mEpc      = excValid ? mEpc : wdata;
                cp0Pkg::regBadVAddr: mBadVAddr = excValid ? mBadVAddr : wdata;
                cp0Pkg::regCause:    mIpSoft   = wdata[9:8];
                cp0Pkg::regConfig:   mConfig   = wdata;
                default: ;
            endcase
        end
    endtask

    function automatic logic [7:0] expPending();
        return {mHwSync[5] | mTimerPending, mHwSync[4:0], mIpSoft};
    endfunction

    function automatic logic [31:0] expRead(input logic [4:0] addr);
        case (addr)
            cp0Pkg::regBadVAddr: return mBadVAddr;
            cp0Pkg::regCount:    return mCount;
            cp0Pkg::regCompare:  return mCompare;
            cp0Pkg::regStatus:   return mStatus;
            cp0Pkg::regCause:    return {mBd, 15'd0, expPending(), 1'b0, mExcCode, 2'b00};
            cp0Pkg::regEpc:      return mEpc;
            cp0Pkg::regPrid:     return cp0Pkg::pridValue;
            cp0Pkg::regConfig:   return mConfig;
            default:             return '0;
        endcase
    endfunction

    task automatic compareValue(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkOutputs();
        logic expIntReq;
        logic [31:0] expVector;
        expIntReq = mStatus[0] && !mStatus[1] && |(expPending() & mStatus[15:8]);
        expVector = mStatus[22] ? cp0Pkg::vectorBoot : cp0Pkg::vectorNormal;
        compareValue("rdata", expRead(raddr), rdata);
        compareValue("intReq", {31'd0, expIntReq}, {31'd0, intReq});
        compareValue("excVector", expVector, excVector);
        compareValue("epcOut", mEpc, epcOut);
        compareValue("kernelMode", {31'd0, mStatus[1]}, {31'd0, kernelMode});
    endtask

    // mtc0 to Status in the same cycle as an exception or eret
    task automatic addStatusWrite();
        if (takeBits(2) == 32'd0) begin
            we    <= 1'b1;
            waddr <= cp0Pkg::regStatus;
            wdata <= takeBits(32);
        end
    endtask

    task automatic driveStimulus(input int cyc);
        logic [2:0]  op;
        logic [4:0]  target;
        logic [31:0] data;
        we       <= 1'b0;
        excValid <= 1'b0;
        eret     <= 1'b0;
        if (cyc < sweepCycles) begin
            raddr <= 5'(cyc);
            return;
        end
        raddr <= pickReg(4'(takeBits(4)));
        op = 3'(takeBits(3));
        case (op)
            3'd2, 3'd3: begin
                target = pickReg(4'(takeBits(4)));
                data   = takeBits(32);
                if (target == cp0Pkg::regCount || target == cp0Pkg::regCompare) begin
                    data = takeBits(7); // small, so Count meets Compare
                end
                we    <= 1'b1;
                waddr <= target;
                wdata <= data;
            end
            3'd4: begin
                data = takeBits(30);
                excValid   <= 1'b1;
                excCode    <= pickExc(3'(takeBits(3)));
                excPc      <= data << 2;
                excBadAddr <= takeBits(32);
                excInDelay <= 1'(takeBits(1));
                eret       <= 1'(takeBits(1));
                addStatusWrite();
            end
            3'd5: begin
                eret <= 1'b1;
                addStatusWrite();
            end
            3'd6, 3'd7: hwInt <= 6'(takeBits(6));
            default: ;
        endcase
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        we         = 1'b0;
        waddr      = '0;
        wdata      = '0;
        raddr      = '0;
        hwInt      = '0;
        excValid   = 1'b0;
        excCode    = '0;
        excPc      = '0;
        excBadAddr = '0;
        excInDelay = 1'b0;
        eret       = 1'b0;
        lfsrState  = 32'd67;
        errorCount = 0;
        checkCount = 0;
        resetModel();
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
        for (int cyc = 0; cyc < totalCycles; cyc++) begin
            @(posedge clk);
            stepModel();
            driveStimulus(cyc);
            @(negedge clk); // outputs settled
            checkOutputs();
        end
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #((totalCycles + resetCycles + 100) * clkPeriod);
        $display("timeout: the test cycles did not complete in time");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/cp0Sva.sv
`default_nettype none

module cp0Sva (
    input logic                         clk,
    input logic                         rst,
    input logic [4:0]                   raddr,
    input logic [cp0Pkg::dataWidth-1:0] rdata,
    input logic                         excValid,
    input logic                         intReq,
    input logic                         kernelMode
);

    logic implemented;

    assign implemented = raddr inside {cp0Pkg::regBadVAddr, cp0Pkg::regCount,
                                       cp0Pkg::regCompare, cp0Pkg::regStatus,
                                       cp0Pkg::regCause, cp0Pkg::regEpc,
                                       cp0Pkg::regPrid, cp0Pkg::regConfig};

    // interrupts are held off at exception level
    noIntInKernel: assert property (@(posedge clk) disable iff (rst) kernelMode |-> !intReq)
        else $error("intReq is high while kernelMode is set");

    excSetsKernel: assert property (@(posedge clk) disable iff (rst) excValid |=> kernelMode)
        else $error("kernelMode is not set in the cycle after an exception");

    unimplReadsZero: assert property (@(posedge clk) disable iff (rst)
                                      !implemented |-> rdata == '0)
        else $error("an unimplemented register number read back nonzero");

endmodule

bind cp0Top cp0Sva uSva (
    .clk       (clk),
    .rst       (rst),
    .raddr     (raddr),
    .rdata     (rdata),
    .excValid  (excValid),
    .intReq    (intReq),
    .kernelMode(kernelMode)
);

`default_nettype wire

//--- hw/cp0Top.sv
`default_nettype none

module cp0Top #(
    parameter int countDivider = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         we,
    input  logic [4:0]                   waddr,
    input  logic [cp0Pkg::dataWidth-1:0] wdata,
    input  logic [4:0]                   raddr,
    input  logic [5:0]                   hwInt,
    input  logic                         excValid,
    input  logic [4:0]                   excCode,
    input  logic [cp0Pkg::dataWidth-1:0] excPc,
    input  logic [cp0Pkg::dataWidth-1:0] excBadAddr,
    input  logic                         excInDelay,
    input  logic                         eret,
    output logic [cp0Pkg::dataWidth-1:0] rdata,
    output logic                         intReq,
    output logic [cp0Pkg::dataWidth-1:0] excVector,
    output logic [cp0Pkg::dataWidth-1:0] epcOut,
    output logic                         kernelMode
);

    logic [cp0Pkg::dataWidth-1:0] count;
    logic [cp0Pkg::dataWidth-1:0] compare;
    logic                         timerPending;
    logic [7:0]                   ipPending;
    logic [7:0]                   statusIm;
    logic                         statusIe;
    logic                         statusExl;
    logic [1:0]                   causeIpSoft;

    cp0Timer #(
        .countDivider(countDivider)
    ) uTimer (
        .clk         (clk),
        .rst         (rst),
        .we          (we),
        .waddr       (waddr),
        .wdata       (wdata),
        .count       (count),
        .compare     (compare),
        .timerPending(timerPending)
    );

    cp0IntCtrl uIntCtrl (
        .clk         (clk),
        .rst         (rst),
        .hwInt       (hwInt),
        .timerPending(timerPending),
        .causeIpSoft (causeIpSoft),
        .statusIm    (statusIm),
        .statusIe    (statusIe),
        .statusExl   (statusExl),
        .ipPending   (ipPending),
        .intReq      (intReq)
    );

    cp0Regs uRegs (
        .clk        (clk),
        .rst        (rst),
        .we         (we),
        .waddr      (waddr),
        .wdata      (wdata),
        .raddr      (raddr),
        .count      (count),
        .compare    (compare),
        .ipPending  (ipPending),
        .excValid   (excValid),
        .excCode    (excCode),
        .excPc      (excPc),
        .excBadAddr (excBadAddr),
        .excInDelay (excInDelay),
        .eret       (eret),
        .rdata      (rdata),
        .statusIm   (statusIm),
        .statusIe   (statusIe),
        .statusExl  (statusExl),
        .causeIpSoft(causeIpSoft),
        .excVector  (excVector),
        .epcOut     (epcOut),
        .kernelMode (kernelMode)
    );

endmodule

`default_nettype wire

//--- hw/cp0Regs.sv
`default_nettype none

module cp0Regs (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         we,
    input  logic [4:0]                   waddr,
    input  logic [cp0Pkg::dataWidth-1:0] wdata,
    input  logic [4:0]                   raddr,
    input  logic [cp0Pkg::dataWidth-1:0] count,
    input  logic [cp0Pkg::dataWidth-1:0] compare,
    input  logic [7:0]                   ipPending,
    input  logic                         excValid,
    input  logic [4:0]                   excCode,
    input  logic [cp0Pkg::dataWidth-1:0] excPc,
    input  logic [cp0Pkg::dataWidth-1:0] excBadAddr,
    input  logic                         excInDelay,
    input  logic                         eret,
    output logic [cp0Pkg::dataWidth-1:0] rdata,
    output logic [7:0]                   statusIm,
    output logic                         statusIe,
    output logic                         statusExl,
    output logic [1:0]                   causeIpSoft,
    output logic [cp0Pkg::dataWidth-1:0] excVector,
    output logic [cp0Pkg::dataWidth-1:0] epcOut,
    output logic                         kernelMode
);

    logic [cp0Pkg::dataWidth-1:0] statusReg;
    logic [cp0Pkg::dataWidth-1:0] epcReg;
    logic [cp0Pkg::dataWidth-1:0] badVAddrReg;
    logic [cp0Pkg::dataWidth-1:0] configReg;
    logic [cp0Pkg::dataWidth-1:0] causeWord;
    logic                         causeBd;
    logic [4:0]                   causeExcCode;

    logic statusWrite;
    logic causeWrite;
    logic epcWrite;
    logic badVAddrWrite;
    logic configWrite;
    logic addrError;

    assign statusWrite   = we && (waddr == cp0Pkg::regStatus);
    assign causeWrite    = we && (waddr == cp0Pkg::regCause);
    assign epcWrite      = we && (waddr == cp0Pkg::regEpc);
    assign badVAddrWrite = we && (waddr == cp0Pkg::regBadVAddr);
    assign configWrite   = we && (waddr == cp0Pkg::regConfig);

    assign addrError = (excCode == cp0Pkg::excAdEL) || (excCode == cp0Pkg::excAdES);

    // Status: exception entry, then eret, then mtc0
    // a Status write in the same cycle as either strobe is dropped
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            statusReg <= cp0Pkg::statusResetValue;
        end else if (excValid) begin
            statusReg[1] <= 1'b1;            // EXL
        end else if (eret) begin
            statusReg[1] <= 1'b0;
        end else if (statusWrite) begin
            statusReg[15:8] <= wdata[15:8];  // IM
            statusReg[1]    <= wdata[1];
            statusReg[0]    <= wdata[0];     // IE
        end
    end

    // Cause fields set by hardware on exception entry
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            causeBd      <= 1'b0;
            causeExcCode <= '0;
        end else if (excValid) begin
            causeExcCode <= excCode;
            if (!statusReg[1]) begin
                causeBd <= excInDelay; // BD only tracks the outermost exception
            end
        end
    end

    // software interrupt bits, the only writable part of Cause
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            causeIpSoft <= '0;
        end else if (causeWrite) begin
            causeIpSoft <= wdata[9:8];
        end
    end

    // nested exceptions keep the first EPC
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            epcReg <= '0;
        end else if (excValid) begin
            if (!statusReg[1]) begin
                epcReg <= excInDelay ? (excPc - 32'd4) : excPc; // restart at the branch
            end
        end else if (epcWrite) begin
            epcReg <= wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            badVAddrReg <= '0;
        end else if (excValid) begin
            if (addrError) begin
                badVAddrReg <= excBadAddr;
            end
        end else if (badVAddrWrite) begin
            badVAddrReg <= wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            configReg <= cp0Pkg::configResetValue;
        end else if (configWrite) begin
            configReg <= wdata;
        end
    end

    // IP field shows live pending lines, soft bits included
    assign causeWord = {causeBd, 15'd0, ipPending, 1'b0, causeExcCode, 2'b00};

    always_comb begin
        case (raddr)
            cp0Pkg::regBadVAddr: rdata = badVAddrReg;
            cp0Pkg::regCount:    rdata = count;
            cp0Pkg::regCompare:  rdata = compare;
            cp0Pkg::regStatus:   rdata = statusReg;
            cp0Pkg::regCause:    rdata = causeWord;
            cp0Pkg::regEpc:      rdata = epcReg;
            cp0Pkg::regPrid:     rdata = cp0Pkg::pridValue;
            cp0Pkg::regConfig:   rdata = configReg;
            default:             rdata = '0; // TLB, watch, debug and the rest
        endcase
    end

    assign statusIm   = statusReg[15:8];
    assign statusIe   = statusReg[0];
    assign statusExl  = statusReg[1];
    assign kernelMode = statusReg[1];
    assign epcOut     = epcReg;

    // BEV picks the bootstrap vector
    assign excVector = statusReg[22] ? cp0Pkg::vectorBoot : cp0Pkg::vectorNormal;

endmodule

`default_nettype wire

//--- hw/cp0IntCtrl.sv
`default_nettype none

module cp0IntCtrl (
    input  logic       clk,
    input  logic       rst,
    input  logic [5:0] hwInt,
    input  logic       timerPending,
    input  logic [1:0] causeIpSoft,
    input  logic [7:0] statusIm,
    input  logic       statusIe,
    input  logic       statusExl,
    output logic [7:0] ipPending,
    output logic       intReq
);

    logic [5:0] hwMeta;   // first synchronizer stage
    logic [5:0] hwSync;   // second stage, safe to use

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hwMeta <= '0;
            hwSync <= '0;
        end else begin
            hwMeta <= hwInt;
            hwSync <= hwMeta;
        end
    end

    // IP7 is shared between hw line 5 and the timer
    assign ipPending = {hwSync[5] | timerPending, hwSync[4:0], causeIpSoft};

    // no new interrupts while at exception level
    assign intReq = statusIe && !statusExl && |(ipPending & statusIm);

endmodule

`default_nettype wire

//--- hw/cp0Timer.sv
`default_nettype none

module cp0Timer #(
    parameter int countDivider = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         we,
    input  logic [4:0]                   waddr,
    input  logic [cp0Pkg::dataWidth-1:0] wdata,
    output logic [cp0Pkg::dataWidth-1:0] count,
    output logic [cp0Pkg::dataWidth-1:0] compare,
    output logic                         timerPending
);

    localparam int preWidth = (countDivider > 1) ? $clog2(countDivider) : 1;
    localparam logic [preWidth-1:0] preLast = preWidth'(countDivider - 1);

    logic [preWidth-1:0] prescale;
    logic                countWrite;
    logic                compareWrite;
    logic                tick;

    assign countWrite   = we && (waddr == cp0Pkg::regCount);
    assign compareWrite = we && (waddr == cp0Pkg::regCompare);
    assign tick         = (prescale == preLast); // last cycle of a count period

    // prescaler, restarted by a Count write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prescale <= '0;
        end else if (countWrite || tick) begin
            prescale <= '0;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (countWrite) begin
            count <= wdata; // load wins over the increment
        end else if (tick) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            compare <= '0;
        end else if (compareWrite) begin
            compare <= wdata;
        end
    end

    // sticky until software rewrites Compare
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            timerPending <= 1'b0;
        end else if (compareWrite) begin
            timerPending <= 1'b0;
        end else if (count == compare) begin
            timerPending <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/cp0Pkg.sv
`default_nettype none

package cp0Pkg;

    localparam int dataWidth = 32;

    // implemented register numbers, everything else reads as zero
    typedef enum logic [4:0] {
        regBadVAddr = 5'd8,
        regCount    = 5'd9,
        regCompare  = 5'd11,
        regStatus   = 5'd12,
        regCause    = 5'd13,
        regEpc      = 5'd14,
        regPrid     = 5'd15,
        regConfig   = 5'd16
    } cp0RegE;

    // Cause.ExcCode values the pipeline can raise
    typedef enum logic [4:0] {
        excInt  = 5'd0,  // interrupt
        excAdEL = 5'd4,  // address error on load or fetch
        excAdES = 5'd5,  // address error on store
        excSys  = 5'd8,  // syscall
        excBp   = 5'd9,  // breakpoint
        excRI   = 5'd10, // reserved instruction
        excOv   = 5'd12  // arithmetic overflow
    } excCodeE;

    localparam logic [dataWidth-1:0] pridValue = 32'h0001_8001;

    // bit 15 set, big-endian flag as in the classic cores
    localparam logic [dataWidth-1:0] configResetValue = 32'h0000_8000;

    // BEV=1, IM=8'hFF, EXL=0, IE=1
    localparam logic [dataWidth-1:0] statusResetValue = 32'h0040_FF01;

    localparam logic [dataWidth-1:0] vectorBoot   = 32'hBFC0_0380;
    localparam logic [dataWidth-1:0] vectorNormal = 32'h8000_0380;

endpackage

`default_nettype wire
